// ==== hw/revo_settings.svh ====
`ifndef REVO_SETTINGS_SVH
`define REVO_SETTINGS_SVH

// buckets in one revolution
`define REVO_BUCKETS 40

// revolutions in one frame9 period
`define FRAME_REVOS 9

`define BUCKET_WIDTH 6
`define REVO_INDEX_WIDTH 4

// prescale is 2**prescale_log2
`define PRESCALE_WIDTH 5

`define MARKER_COUNT 4

`endif

// ==== hw/revo_pkg.sv ====
`include "revo_settings.svh"

package revo_pkg;

	// where the receiver thinks the beam is
	typedef struct packed {
		logic valid;
		logic [`BUCKET_WIDTH-1:0] bucket;
		logic [`REVO_INDEX_WIDTH-1:0] revo_index;
	} revo_position_t;

	// one bit of revo_mask per revolution of the frame9 period
	typedef struct packed {
		logic enable;
		logic [`BUCKET_WIDTH-1:0] bucket;
		logic [`FRAME_REVOS-1:0] revo_mask;
	} bunch_marker_t;

	typedef bunch_marker_t [`MARKER_COUNT-1:0] marker_set_t;

	typedef logic [1:0] marker_id_t;

	typedef enum logic {
		RX_SEARCH,
		RX_LOCKED
	} rx_state_t;

	typedef enum logic {
		GEN_IDLE,
		GEN_RUN
	} gen_state_t;

endpackage

// ==== hw/revo_generator.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module revo_generator (
	input  logic clock,
	input  logic rst,
	input  logic generator_enable,
	output logic revo_out
);
	import revo_pkg::*;

	localparam logic [`BUCKET_WIDTH-1:0] LAST_BUCKET = `BUCKET_WIDTH'(`REVO_BUCKETS - 1);

	gen_state_t state;
	logic [`BUCKET_WIDTH-1:0] bucket;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= GEN_IDLE;
			bucket <= '0;
			revo_out <= 1'b0;
		end else begin
			revo_out <= 1'b0;
			case (state)
				GEN_IDLE: begin
					if (generator_enable) begin
						state <= GEN_RUN;
						bucket <= '0;
						revo_out <= 1'b1; // first revo right away
					end
				end
				GEN_RUN: begin
					if (!generator_enable) begin
						state <= GEN_IDLE;
						bucket <= '0;
					end else if (bucket == LAST_BUCKET) begin
						bucket <= '0;
						revo_out <= 1'b1;
					end else begin
						bucket <= bucket + 1'b1;
					end
				end
				default: state <= GEN_IDLE;
			endcase
		end
	end

endmodule

// ==== hw/revo_receiver.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module revo_receiver (
	input  logic clock,
	input  logic rst,
	input  logic revo_in,
	output revo_pkg::revo_position_t position,
	output logic frame,
	output logic frame9,
	output logic revo_error
);
	import revo_pkg::*;

	localparam logic [`BUCKET_WIDTH-1:0] LAST_BUCKET = `BUCKET_WIDTH'(`REVO_BUCKETS - 1);
	localparam logic [`REVO_INDEX_WIDTH-1:0] LAST_INDEX = `REVO_INDEX_WIDTH'(`FRAME_REVOS - 1);

	rx_state_t state;
	logic at_wrap;
	logic [`REVO_INDEX_WIDTH-1:0] next_index;

	assign at_wrap = (position.bucket == LAST_BUCKET);
	assign next_index = (position.revo_index == LAST_INDEX) ? '0 : position.revo_index + 1'b1;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= RX_SEARCH;
			position <= '0;
			frame <= 1'b0;
			frame9 <= 1'b0;
			revo_error <= 1'b0;
		end else begin
			frame <= 1'b0;
			frame9 <= 1'b0;
			revo_error <= 1'b0;
			case (state)
				RX_SEARCH: begin
					if (revo_in) begin
						state <= RX_LOCKED;
						position <= '{valid: 1'b1, bucket: '0, revo_index: '0};
						frame <= 1'b1;
						frame9 <= 1'b1;
					end
				end
				RX_LOCKED: begin
					if (at_wrap && revo_in) begin
						// revo where we predicted it
						position.bucket <= '0;
						position.revo_index <= next_index;
						frame <= 1'b1;
						frame9 <= (next_index == '0);
					end else if (at_wrap) begin
						// revo missing so the lock is gone
						state <= RX_SEARCH;
						position <= '0;
						revo_error <= 1'b1;
					end else if (revo_in) begin
						// misplaced revo restarts the lock here
						position <= '{valid: 1'b1, bucket: '0, revo_index: '0};
						revo_error <= 1'b1;
						frame <= 1'b1;
						frame9 <= 1'b1;
					end else begin
						position.bucket <= position.bucket + 1'b1;
					end
				end
				default: state <= RX_SEARCH;
			endcase
		end
	end

endmodule

// ==== hw/bunch_marker_table.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module bunch_marker_table (
	input  logic clock,
	input  logic rst,
	input  logic cfg_write,
	input  revo_pkg::marker_id_t cfg_index,
	input  revo_pkg::bunch_marker_t cfg_marker,
	output revo_pkg::marker_set_t markers
);
	import revo_pkg::*;

	logic [`MARKER_COUNT-1:0] write_select;

	// one-hot write enable per marker
	always_comb begin
		write_select = '0;
		for (int i = 0; i < `MARKER_COUNT; i++) begin
			if (cfg_index == marker_id_t'(i)) begin
				write_select[i] = cfg_write;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			markers <= '0; // all disabled
		end else begin
			for (int i = 0; i < `MARKER_COUNT; i++) begin
				if (write_select[i]) begin
					markers[i] <= cfg_marker;
				end
			end
		end
	end

endmodule

// ==== hw/trigger_generator.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module trigger_generator (
	input  logic clock,
	input  logic rst,
	input  revo_pkg::revo_position_t position,
	input  revo_pkg::marker_set_t markers,
	input  logic trigger_enable,
	input  logic [`PRESCALE_WIDTH-1:0] prescale_log2,
	output logic xrm_trigger,
	output revo_pkg::marker_id_t trigger_marker
);
	import revo_pkg::*;

	// wide enough for the largest prescale exponent
	localparam int COUNT_WIDTH = 1 << `PRESCALE_WIDTH;

	logic [`MARKER_COUNT-1:0] hit;
	logic any_hit;
	marker_id_t hit_id;
	logic [COUNT_WIDTH-1:0] hit_count;
	logic [COUNT_WIDTH-1:0] prescale_mask;
	logic selected;

	always_comb begin
		for (int i = 0; i < `MARKER_COUNT; i++) begin
			hit[i] = markers[i].enable && position.valid
				&& (markers[i].bucket == position.bucket)
				&& markers[i].revo_mask[position.revo_index];
		end
	end

	// lowest marker wins
	always_comb begin
		any_hit = 1'b0;
		hit_id = '0;
		for (int i = `MARKER_COUNT - 1; i >= 0; i--) begin
			if (hit[i]) begin
				any_hit = 1'b1;
				hit_id = marker_id_t'(i);
			end
		end
	end

	assign prescale_mask = (COUNT_WIDTH'(1) << prescale_log2) - 1'b1;
	assign selected = ((hit_count & prescale_mask) == '0);

	always_ff @(posedge clock) begin
		if (rst) begin
			hit_count <= '0;
			xrm_trigger <= 1'b0;
		end else begin
			xrm_trigger <= trigger_enable && any_hit && selected;
			if (!trigger_enable) begin
				hit_count <= '0; // first hit after enable always fires
			end else if (any_hit) begin
				hit_count <= hit_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (any_hit) begin
			trigger_marker <= hit_id;
		end
	end

endmodule

// ==== hw/revo_trigger_system.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module revo_trigger_system (
	input  logic clock,
	input  logic rst,
	input  logic generator_enable,
	output logic revo_out,
	input  logic revo_in,
	input  logic cfg_write,
	input  revo_pkg::marker_id_t cfg_index,
	input  revo_pkg::bunch_marker_t cfg_marker,
	input  logic trigger_enable,
	input  logic [`PRESCALE_WIDTH-1:0] prescale_log2,
	output logic frame,
	output logic frame9,
	output logic revo_error,
	output logic xrm_trigger,
	output revo_pkg::marker_id_t trigger_marker
);
	import revo_pkg::*;

	revo_position_t position;
	marker_set_t markers;

	// transmitting side that leaves the chip
	revo_generator generator (
		.clock(clock),
		.rst(rst),
		.generator_enable(generator_enable),
		.revo_out(revo_out)
	);

	revo_receiver receiver (
		.clock(clock),
		.rst(rst),
		.revo_in(revo_in),
		.position(position),
		.frame(frame),
		.frame9(frame9),
		.revo_error(revo_error)
	);

	bunch_marker_table marker_table (
		.clock(clock),
		.rst(rst),
		.cfg_write(cfg_write),
		.cfg_index(cfg_index),
		.cfg_marker(cfg_marker),
		.markers(markers)
	);

	trigger_generator trigger (
		.clock(clock),
		.rst(rst),
		.position(position),
		.markers(markers),
		.trigger_enable(trigger_enable),
		.prescale_log2(prescale_log2),
		.xrm_trigger(xrm_trigger),
		.trigger_marker(trigger_marker)
	);

endmodule

// ==== sim/revo_trigger_system_properties.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module revo_trigger_system_properties (
	input logic clock,
	input logic rst,
	input logic generator_enable,
	input logic revo_out,
	input logic revo_in,
	input logic trigger_enable,
	input revo_pkg::revo_position_t position,
	input logic frame,
	input logic frame9,
	input logic revo_error,
	input logic xrm_trigger
);
	int failure_count = 0;
	logic seen_revo;

	always_ff @(posedge clock) begin
		if (rst) begin
			seen_revo <= 1'b0;
		end else if (revo_in) begin
			seen_revo <= 1'b1;
		end
	end

	// next frame one revolution later unless the lock breaks
	frame_spacing: assert property (@(posedge clock) disable iff (rst || revo_error)
		frame |-> ##`REVO_BUCKETS (frame || revo_error))
		else begin
			failure_count++;
			$error("frames not one revolution apart");
		end

	frame_from_revo: assert property (@(posedge clock) disable iff (rst)
		frame |-> $past(revo_in))
		else begin
			failure_count++;
			$error("frame without a revo before it");
		end

	frame9_with_frame: assert property (@(posedge clock) disable iff (rst)
		frame9 |-> frame)
		else begin
			failure_count++;
			$error("frame9 without frame");
		end

	quiet_until_revo: assert property (@(posedge clock) disable iff (rst)
		(frame || frame9 || revo_error || xrm_trigger) |-> seen_revo)
		else begin
			failure_count++;
			$error("pulse output before the first revo");
		end

	error_when_locked: assert property (@(posedge clock) disable iff (rst)
		revo_error |-> $past(position.valid))
		else begin
			failure_count++;
			$error("revo_error while not locked");
		end

	trigger_gating: assert property (@(posedge clock) disable iff (rst)
		xrm_trigger |-> ($past(trigger_enable) && $past(position.valid)))
		else begin
			failure_count++;
			$error("trigger while disabled or unlocked");
		end

	generator_start: assert property (@(posedge clock) disable iff (rst)
		$rose(generator_enable) |=> revo_out)
		else begin
			failure_count++;
			$error("no revo right after generator enable");
		end

endmodule

bind revo_trigger_system revo_trigger_system_properties props (
	.clock(clock),
	.rst(rst),
	.generator_enable(generator_enable),
	.revo_out(revo_out),
	.revo_in(revo_in),
	.trigger_enable(trigger_enable),
	.position(position),
	.frame(frame),
	.frame9(frame9),
	.revo_error(revo_error),
	.xrm_trigger(xrm_trigger)
);

// ==== sim/revo_trigger_system_tb.sv ====
`timescale 1ns/1ps
`include "revo_settings.svh"

module revo_trigger_system_tb;
	import revo_pkg::*;

	// 8 frame9 periods plus setup
	localparam int CYCLE_LIMIT = 8 * `FRAME_REVOS * `REVO_BUCKETS + 200;

	logic clock;
	logic rst;
	logic generator_enable;
	logic revo_out;
	logic revo_in = 1'b0;
	logic cfg_write;
	marker_id_t cfg_index;
	bunch_marker_t cfg_marker;
	logic trigger_enable;
	logic [`PRESCALE_WIDTH-1:0] prescale_log2;
	logic frame;
	logic frame9;
	logic revo_error;
	logic xrm_trigger;
	marker_id_t trigger_marker;

	logic late_revo = 1'b0;
	int drop_asked = 0;
	int drop_done = 0;
	int delay_asked = 0;
	int delay_done = 0;

	// reference model state
	logic model_live = 1'b0;
	logic m_locked;
	logic m_valid;
	int m_bucket;
	int m_index;
	int unsigned m_hits;
	marker_set_t m_markers;
	logic exp_frame;
	logic exp_frame9;
	logic exp_error;
	logic exp_trigger;
	marker_id_t exp_marker;

	int error_count = 0;
	int triggers_expected = 0;
	int triggers_seen = 0;
	int cycle_count = 0;
	string test_name = "reset";
	int shared_bucket;

	revo_trigger_system UUT (
		.clock(clock),
		.rst(rst),
		.generator_enable(generator_enable),
		.revo_out(revo_out),
		.revo_in(revo_in),
		.cfg_write(cfg_write),
		.cfg_index(cfg_index),
		.cfg_marker(cfg_marker),
		.trigger_enable(trigger_enable),
		.prescale_log2(prescale_log2),
		.frame(frame),
		.frame9(frame9),
		.revo_error(revo_error),
		.xrm_trigger(xrm_trigger),
		.trigger_marker(trigger_marker)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// loopback from revo_out to revo_in with one cycle of cable delay
	always @(negedge clock) begin
		revo_in <= late_revo;
		late_revo <= 1'b0;
		if (revo_out) begin
			if (drop_done != drop_asked) begin
				drop_done <= drop_done + 1; // lost on the way
			end else if (delay_done != delay_asked) begin
				delay_done <= delay_done + 1;
				late_revo <= 1'b1;
			end else begin
				revo_in <= 1'b1;
			end
		end
	end

	task automatic report_mismatch(input string signal, input logic [31:0] expected,
		input logic [31:0] actual);
		error_count++;
		$display("Mismatch in %s: %s expected %0h, actual %0h at %0t", test_name, signal,
			expected, actual, $time);
	endtask

	// lowest enabled marker whose bucket and mask bit match
	task automatic model_trigger();
		logic found;
		marker_id_t id;
		logic [`FRAME_REVOS-1:0] shifted;
		found = 1'b0;
		id = '0;
		for (int i = 0; i < `MARKER_COUNT; i++) begin
			shifted = m_markers[i].revo_mask >> m_index;
			if (!found && m_valid && m_markers[i].enable && shifted[0]
				&& int'(m_markers[i].bucket) == m_bucket) begin
				found = 1'b1;
				id = marker_id_t'(i);
			end
		end
		exp_trigger = trigger_enable && found
			&& ((m_hits % (32'd1 << prescale_log2)) == 0);
		if (found) exp_marker = id;
		if (!trigger_enable) m_hits = 0;
		else if (found) m_hits++;
		if (exp_trigger) triggers_expected++;
	endtask

	task automatic fresh_lock();
		m_locked = 1'b1;
		m_valid = 1'b1;
		m_bucket = 0;
		m_index = 0;
		exp_frame = 1'b1;
		exp_frame9 = 1'b1;
	endtask

	task automatic model_receiver();
		exp_frame = 1'b0;
		exp_frame9 = 1'b0;
		exp_error = 1'b0;
		if (!m_locked) begin
			if (revo_in) fresh_lock();
		end else if (m_bucket == `REVO_BUCKETS - 1) begin
			if (revo_in) begin
				m_bucket = 0;
				m_index = (m_index + 1) % `FRAME_REVOS;
				exp_frame = 1'b1;
				exp_frame9 = (m_index == 0);
			end else begin
				m_locked = 1'b0; // revo never came
				m_valid = 1'b0;
				m_bucket = 0;
				m_index = 0;
				exp_error = 1'b1;
			end
		end else if (revo_in) begin
			fresh_lock();
			exp_error = 1'b1;
		end else begin
			m_bucket++;
		end
	endtask

	always @(posedge clock) begin
		if (rst) begin
			model_live = 1'b0;
			m_locked = 1'b0;
			m_valid = 1'b0;
			m_bucket = 0;
			m_index = 0;
			m_hits = 0;
			m_markers = '0;
			exp_frame = 1'b0;
			exp_frame9 = 1'b0;
			exp_error = 1'b0;
			exp_trigger = 1'b0;
		end else begin
			model_live = 1'b1;
			model_trigger(); // sees the position from before this edge
			model_receiver();
			if (cfg_write) m_markers[cfg_index] = cfg_marker;
		end
	end

	// outputs settled half a cycle after the edge
	always @(negedge clock) begin
		if (model_live) begin
			assert (frame === exp_frame)
				else report_mismatch("frame", 32'(exp_frame), 32'(frame));
			assert (frame9 === exp_frame9)
				else report_mismatch("frame9", 32'(exp_frame9), 32'(frame9));
			assert (revo_error === exp_error)
				else report_mismatch("revo_error", 32'(exp_error), 32'(revo_error));
			assert (xrm_trigger === exp_trigger)
				else report_mismatch("xrm_trigger", 32'(exp_trigger), 32'(xrm_trigger));
			if (xrm_trigger === 1'b1) triggers_seen++;
			if (xrm_trigger === 1'b1 && exp_trigger) begin
				assert (trigger_marker === exp_marker)
					else report_mismatch("trigger_marker", 32'(exp_marker), 32'(trigger_marker));
			end
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic begin_test(input string name);
		@(posedge clock);
		test_name = name;
	endtask

	task automatic wait_frames(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge clock);
			while (!frame) @(negedge clock);
		end
	endtask

	task automatic wait_error();
		@(negedge clock);
		while (!revo_error) @(negedge clock);
	endtask

	task automatic write_marker(input marker_id_t index, input logic enable, input int bucket,
		input int mask);
		@(negedge clock);
		cfg_write = 1'b1;
		cfg_index = index;
		cfg_marker.enable = enable;
		cfg_marker.bucket = `BUCKET_WIDTH'(bucket);
		cfg_marker.revo_mask = `FRAME_REVOS'(mask);
		@(negedge clock);
		cfg_write = 1'b0;
	endtask

	initial begin
		void'($urandom(92485));
		rst = 1'b1;
		generator_enable = 1'b0;
		cfg_write = 1'b0;
		cfg_index = '0;
		cfg_marker = '0;
		trigger_enable = 1'b0;
		prescale_log2 = '0;
		repeat (5) @(negedge clock);
		rst = 1'b0;

		begin_test("idle");
		repeat (20) @(negedge clock);

		begin_test("prescale 1");
		shared_bucket = int'($urandom_range(`REVO_BUCKETS - 1, 0));
		write_marker(2'd0, 1'b1, shared_bucket, int'($urandom_range(511, 0)));
		write_marker(2'd1, 1'b1, shared_bucket, int'($urandom_range(511, 0))); // same bucket
		write_marker(2'd2, 1'b1, int'($urandom_range(`REVO_BUCKETS - 1, 0)),
			int'($urandom_range(511, 0)));
		write_marker(2'd3, 1'b0, int'($urandom_range(`REVO_BUCKETS - 1, 0)), 511);
		@(negedge clock);
		trigger_enable = 1'b1;
		generator_enable = 1'b1;
		wait_frames(2 * `FRAME_REVOS);

		begin_test("dropped revo");
		drop_asked++;
		wait_error();
		wait_frames(2);

		begin_test("delayed revo");
		delay_asked++;
		wait_error();
		wait_frames(2);

		begin_test("prescale 4");
		@(negedge clock);
		trigger_enable = 1'b0;
		prescale_log2 = `PRESCALE_WIDTH'(2);
		@(negedge clock);
		trigger_enable = 1'b1;
		wait_frames(2 * `FRAME_REVOS);

		begin_test("trigger disabled");
		@(negedge clock);
		trigger_enable = 1'b0;
		wait_frames(4);

		begin_test("marker rewrite");
		@(negedge clock);
		trigger_enable = 1'b1;
		prescale_log2 = '0;
		write_marker(2'd0, 1'b1, int'($urandom_range(`REVO_BUCKETS - 1, 0)), 511);
		wait_frames(`FRAME_REVOS);

		begin_test("trigger count");
		@(negedge clock);
		trigger_enable = 1'b0; // no trigger can be in flight when counting
		repeat (2) @(negedge clock);
		assert (triggers_seen == triggers_expected)
			else report_mismatch("trigger count", 32'(triggers_expected), 32'(triggers_seen));
		if (triggers_expected == 0) begin
			error_count++;
			$display("no trigger was expected, the markers were never reached");
		end

		$display("errors: %0d checks, %0d assertions", error_count, UUT.props.failure_count);
		if (error_count == 0 && UUT.props.failure_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== revo_trigger_system.f ====
+incdir+hw
hw/revo_pkg.sv
hw/revo_generator.sv
hw/revo_receiver.sv
hw/bunch_marker_table.sv
hw/trigger_generator.sv
hw/revo_trigger_system.sv
sim/revo_trigger_system_properties.sv
sim/revo_trigger_system_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the revo trigger testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module revo_trigger_system_tb \
	-f revo_trigger_system.f \
	-o revo_trigger_system_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

# keep running after assertion errors so the testbench prints its verdict
./obj_dir/revo_trigger_system_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
	exit 0
fi
echo "simulation did not pass, see $LOG"
exit 1
